/* console_defs.svh */
`ifndef CONSOLE_DEFS_SVH
`define CONSOLE_DEFS_SVH

// ==============================
// Host download bus
// ==============================
`define IOCTL_ADDR_W  25
`define IOCTL_DATA_W  8

// Cartridge ROM
`define ROM_ADDR_W    22  // Read address and mask
`define ROMWR_ADDR_W  24  // Write counter

// Backup RAM sectors
`define SD_LBA_W      32
`define BK_SECTOR_W   6   // 64 sectors

`define CE_PERIOD     30  // Enable cycle length in clk_sys cycles
`define CODE_BYTES    16

// Download indices
`define IDX_CHEAT     255
`define IDX_HANDHELD  2
`define IDX_ARCADE    3

`endif

/* console_pkg.sv */
`include "console_defs.svh"

package console_pkg;

	// Cheat code fields, flags in the top word
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_fields_t;

	// Byte view indexed as [field][byte]
	// Field 0 sits at the top, bytes are little-endian inside a field
	typedef logic [0:`CODE_BYTES/4-1][3:0][7:0] cheat_bytes_t;

	typedef union packed {
		cheat_bytes_t  bytes;   // Written by the loader
		cheat_fields_t fields;  // Read by the core
	} cheat_code_u;

endpackage

/* download_if.sv */
`timescale 1ns/100ps
`include "console_defs.svh"

interface download_if;

	logic                       ioctl_download; // High for a whole transfer
	logic [7:0]                 ioctl_index;
	logic                       ioctl_wr;       // One cycle per byte
	logic [`IOCTL_ADDR_W-1:0]   ioctl_addr;
	logic [`IOCTL_DATA_W-1:0]   ioctl_dout;

	modport host (
		output ioctl_download, ioctl_index, ioctl_wr, ioctl_addr, ioctl_dout
	);

	modport sink (
		input ioctl_download, ioctl_index, ioctl_wr, ioctl_addr, ioctl_dout
	);

endinterface

/* clock_enable_gen.sv */
`timescale 1ns/100ps
`include "console_defs.svh"

module clock_enable_gen (
	input  logic clk_sys,
	input  logic rst_n,
	output logic ce_cpu,
	output logic ce_vdp,
	output logic ce_pix
);

	localparam int CNT_W = $clog2(`CE_PERIOD);

	logic [CNT_W-1:0] clkd; // Step within the enable cycle

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			clkd   <= '0;
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
			ce_cpu <= 1'b0;
		end else begin
			if (clkd == CNT_W'(`CE_PERIOD - 1)) begin
				clkd <= '0;
			end else begin
				clkd <= clkd + 1'b1;
			end

			// Default low, each strobe lasts one cycle
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
			ce_cpu <= 1'b0;

			case (clkd)
				CNT_W'(4), CNT_W'(14): begin
					ce_vdp <= 1'b1;
				end
				CNT_W'(9): begin
					ce_vdp <= 1'b1;
					ce_pix <= 1'b1;
					ce_cpu <= 1'b1;
				end
				CNT_W'(19), CNT_W'(29): begin
					ce_vdp <= 1'b1;
					ce_pix <= 1'b1;
				end
				CNT_W'(24): begin
					ce_vdp <= 1'b1;
					ce_cpu <= 1'b1; // Second CPU phase, 15 cycles after the first
				end
				default: ;
			endcase
		end
	end

endmodule

/* cart_loader.sv */
`timescale 1ns/100ps
`include "console_defs.svh"

module cart_loader (
	input  logic                       clk_sys,
	input  logic                       rst_n,
	download_if.sink                   dl,
	input  logic                       rom_wr_ack,
	input  logic [`ROM_ADDR_W-1:0]     core_rom_addr,
	output logic                       ioctl_wait,
	output logic                       rom_wr,
	output logic [`ROMWR_ADDR_W-1:0]   rom_waddr,
	output logic [`IOCTL_DATA_W-1:0]   rom_din,
	output logic [`ROM_ADDR_W-1:0]     cart_mask,
	output logic [`ROM_ADDR_W-1:0]     rom_raddr,
	output logic                       sys_handheld,
	output logic                       sys_arcade
);

	logic cart_download;
	logic cart_write;
	logic old_download;

	assign cart_download = dl.ioctl_download & ~|dl.ioctl_index[7:2];
	assign cart_write    = dl.ioctl_wr & cart_download;

	// ==============================
	// Toggle handshake to ROM memory
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			old_download <= 1'b0;
			ioctl_wait   <= 1'b0;
			rom_wr       <= 1'b0;
			rom_waddr    <= '0;
		end else begin
			old_download <= cart_download;
			if (cart_download && !old_download) begin
				rom_waddr <= '0; // New image starts at address 0
			end else if (cart_write) begin
				ioctl_wait <= 1'b1;
				rom_wr     <= ~rom_wr;
			end else if (ioctl_wait && (rom_wr == rom_wr_ack)) begin
				ioctl_wait <= 1'b0;
				rom_waddr  <= rom_waddr + 1'b1;
			end
		end
	end

	// Byte held for the memory until it acks
	always_ff @(posedge clk_sys) begin
		if (cart_write) rom_din <= dl.ioctl_dout;
	end

	// Address mask and system type
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cart_mask    <= '0;
			sys_handheld <= 1'b0;
			sys_arcade   <= 1'b0;
		end else if (cart_write) begin
			if (dl.ioctl_addr == '0) begin
				cart_mask <= '0;
			end else begin
				cart_mask <= cart_mask | dl.ioctl_addr[`ROM_ADDR_W-1:0];
			end
			sys_handheld <= dl.ioctl_index[4:0] == 5'(`IDX_HANDHELD);
			sys_arcade   <= dl.ioctl_index[4:0] == 5'(`IDX_ARCADE);
		end
	end

	assign rom_raddr = core_rom_addr & cart_mask; // Mirrors small images

endmodule

/* cheat_code_loader.sv */
`timescale 1ns/100ps
`include "console_defs.svh"

module cheat_code_loader
	import console_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	download_if.sink    dl,
	output cheat_code_u code,
	output logic        code_valid
);

	localparam int IDX_W = $clog2(`CODE_BYTES);

	logic             code_write;
	logic [IDX_W-1:0] byte_idx;

	assign code_write = dl.ioctl_download & dl.ioctl_wr & (dl.ioctl_index == 8'(`IDX_CHEAT));
	assign byte_idx   = dl.ioctl_addr[IDX_W-1:0];

	// Upper index bits pick the field, lower bits the byte
	always_ff @(posedge clk_sys) begin
		if (code_write) code.bytes[byte_idx[IDX_W-1:2]][byte_idx[1:0]] <= dl.ioctl_dout;
	end

	// Last byte completes the code
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			code_valid <= 1'b0;
		end else begin
			code_valid <= code_write && (byte_idx == IDX_W'(`CODE_BYTES - 1));
		end
	end

endmodule

/* backup_sequencer.sv */
`timescale 1ns/100ps
`include "console_defs.svh"

module backup_sequencer (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	download_if.sink               dl,
	input  logic                   sd_ack,
	input  logic                   img_mounted,
	input  logic                   img_readonly,
	input  logic [63:0]            img_size,
	input  logic                   osd_status,  // Menu open
	input  logic                   bk_load_req,
	input  logic                   bk_save_req,
	input  logic                   autosave_en,
	input  logic                   nvram_we,
	output logic [`SD_LBA_W-1:0]   sd_lba,
	output logic                   sd_rd,
	output logic                   sd_wr,
	output logic                   bk_busy,
	output logic                   bk_loading,
	output logic                   bk_pending
);

	logic cart_download, old_download;
	logic bk_ena;
	logic load_now, save_now;
	logic old_load, old_save, old_ack;

	assign cart_download = dl.ioctl_download & ~|dl.ioctl_index[7:2];
	assign load_now = bk_load_req & bk_ena;
	assign save_now = (bk_save_req | (bk_pending & osd_status & autosave_en)) & bk_ena;

	// Save image is mounted before the cartridge transfer ends
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			old_download <= 1'b0;
			bk_ena       <= 1'b0;
		end else begin
			old_download <= cart_download;
			if (cart_download && !old_download) bk_ena <= 1'b0;
			if (cart_download && img_mounted && !img_readonly) bk_ena <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			bk_pending <= 1'b0;
		end else if (bk_ena && !osd_status && nvram_we) begin
			bk_pending <= 1'b1; // Game wrote backup RAM
		end else if (bk_busy) begin
			bk_pending <= 1'b0;
		end
	end

	// ==============================
	// Sector load/save sequence
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			old_load <= load_now;
			old_save <= save_now;
			old_ack  <= sd_ack;

			if (sd_ack && !old_ack) begin
				sd_rd <= 1'b0; // Host took the request
				sd_wr <= 1'b0;
			end

			if (!bk_busy) begin
				if ((load_now && !old_load) || (save_now && !old_save)) begin
					bk_busy    <= 1'b1;
					bk_loading <= load_now;
					sd_lba     <= '0;
					sd_rd      <= load_now;
					sd_wr      <= ~load_now;
				end
				if (old_download && !cart_download && |img_size && bk_ena) begin
					bk_busy    <= 1'b1;
					bk_loading <= 1'b1;
					sd_lba     <= '0;
					sd_rd      <= 1'b1;
					sd_wr      <= 1'b0;
				end
			end else if (old_ack && !sd_ack) begin
				if (&sd_lba[`BK_SECTOR_W-1:0]) begin
					bk_busy    <= 1'b0; // Last sector done
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 1'b1;
					sd_rd  <= bk_loading;
					sd_wr  <= ~bk_loading;
				end
			end
		end
	end

endmodule

/* console_top.sv */
`timescale 1ns/100ps
`include "console_defs.svh"

module console_top
	import console_pkg::*;
(
	input  logic                       clk_sys,
	input  logic                       rst_n,
	// Host download bus
	input  logic                       ioctl_download,
	input  logic                       ioctl_wr,
	input  logic [7:0]                 ioctl_index,
	input  logic [`IOCTL_ADDR_W-1:0]   ioctl_addr,
	input  logic [`IOCTL_DATA_W-1:0]   ioctl_dout,
	output logic                       ioctl_wait,
	// Clock enables
	output logic                       ce_cpu,
	output logic                       ce_vdp,
	output logic                       ce_pix,
	// Cartridge ROM
	output logic                       rom_wr,
	input  logic                       rom_wr_ack,
	output logic [`ROMWR_ADDR_W-1:0]   rom_waddr,
	output logic [`IOCTL_DATA_W-1:0]   rom_din,
	output logic [`ROM_ADDR_W-1:0]     cart_mask,
	input  logic [`ROM_ADDR_W-1:0]     core_rom_addr,
	output logic [`ROM_ADDR_W-1:0]     rom_raddr,
	output logic                       sys_handheld,
	output logic                       sys_arcade,
	// Cheats
	output cheat_code_u                code,
	output logic                       code_valid,
	// Backup RAM sectors
	output logic [`SD_LBA_W-1:0]       sd_lba,
	output logic                       sd_rd,
	output logic                       sd_wr,
	input  logic                       sd_ack,
	input  logic                       img_mounted,
	input  logic                       img_readonly,
	input  logic [63:0]                img_size,
	input  logic                       osd_status,
	input  logic                       bk_load_req,
	input  logic                       bk_save_req,
	input  logic                       autosave_en,
	input  logic                       nvram_we,
	output logic                       bk_busy,
	output logic                       bk_loading,
	output logic                       bk_pending
);

	download_if dl_bus ();

	assign dl_bus.ioctl_download = ioctl_download;
	assign dl_bus.ioctl_index    = ioctl_index;
	assign dl_bus.ioctl_wr       = ioctl_wr;
	assign dl_bus.ioctl_addr     = ioctl_addr;
	assign dl_bus.ioctl_dout     = ioctl_dout;

	clock_enable_gen ce_gen_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.ce_cpu  (ce_cpu),
		.ce_vdp  (ce_vdp),
		.ce_pix  (ce_pix)
	);

	cart_loader cart_i (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.dl            (dl_bus.sink),
		.rom_wr_ack    (rom_wr_ack),
		.core_rom_addr (core_rom_addr),
		.ioctl_wait    (ioctl_wait),
		.rom_wr        (rom_wr),
		.rom_waddr     (rom_waddr),
		.rom_din       (rom_din),
		.cart_mask     (cart_mask),
		.rom_raddr     (rom_raddr),
		.sys_handheld  (sys_handheld),
		.sys_arcade    (sys_arcade)
	);

	cheat_code_loader cheat_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.dl         (dl_bus.sink),
		.code       (code),
		.code_valid (code_valid)
	);

	backup_sequencer backup_i (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.dl           (dl_bus.sink),
		.sd_ack       (sd_ack),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.osd_status   (osd_status),
		.bk_load_req  (bk_load_req),
		.bk_save_req  (bk_save_req),
		.autosave_en  (autosave_en),
		.nvram_we     (nvram_we),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.bk_busy      (bk_busy),
		.bk_loading   (bk_loading),
		.bk_pending   (bk_pending)
	);

endmodule

/* console_checker.sv */
`timescale 1ns/100ps
`include "console_defs.svh"

module console_checker (
	input logic                       clk_sys,
	input logic                       rst_n,
	input logic                       ce_cpu,
	input logic                       ce_vdp,
	input logic                       sd_rd,
	input logic                       sd_wr,
	input logic                       ioctl_wait,
	input logic [`ROMWR_ADDR_W-1:0]   rom_waddr
);

	int fail_count = 0; // Failed assertions so far

	// ==============================
	// Sector requests and enables
	// ==============================
	sd_req_excl: assert property (@(posedge clk_sys) disable iff (!rst_n) !(sd_rd && sd_wr))
		else begin
			$error("sd_rd and sd_wr high together");
			fail_count++;
		end

	cpu_with_vdp: assert property (@(posedge clk_sys) disable iff (!rst_n) ce_cpu |-> ce_vdp)
		else begin
			$error("ce_cpu without ce_vdp");
			fail_count++;
		end

	// Write address only moves on the edge where wait falls
	waddr_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ioctl_wait |=> (!ioctl_wait || $stable(rom_waddr)))
		else begin
			$error("rom_waddr changed while ioctl_wait was high");
			fail_count++;
		end

	wait_after_reset: assert property (@(posedge clk_sys) !rst_n |=> !ioctl_wait)
		else begin
			$error("ioctl_wait high after reset");
			fail_count++;
		end

endmodule

bind console_top console_checker checker_i (
	.clk_sys    (clk_sys),
	.rst_n      (rst_n),
	.ce_cpu     (ce_cpu),
	.ce_vdp     (ce_vdp),
	.sd_rd      (sd_rd),
	.sd_wr      (sd_wr),
	.ioctl_wait (ioctl_wait),
	.rom_waddr  (rom_waddr)
);

/* console_tb.sv */
`timescale 1ns/100ps
`include "console_defs.svh"

module console_tb
	import console_pkg::*;
();

	// Longest test is the 300-byte image at up to 6 cycles a byte
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int SECTORS        = 1 << `BK_SECTOR_W;

	logic                       clk_sys;
	logic                       rst_n;
	logic                       ioctl_download;
	logic                       ioctl_wr;
	logic [7:0]                 ioctl_index;
	logic [`IOCTL_ADDR_W-1:0]   ioctl_addr;
	logic [`IOCTL_DATA_W-1:0]   ioctl_dout;
	logic                       ioctl_wait;
	logic                       ce_cpu, ce_vdp, ce_pix;
	logic                       rom_wr;
	logic                       rom_wr_ack = 1'b0;
	logic [`ROMWR_ADDR_W-1:0]   rom_waddr;
	logic [`IOCTL_DATA_W-1:0]   rom_din;
	logic [`ROM_ADDR_W-1:0]     cart_mask;
	logic [`ROM_ADDR_W-1:0]     core_rom_addr;
	logic [`ROM_ADDR_W-1:0]     rom_raddr;
	logic                       sys_handheld, sys_arcade;
	cheat_code_u                code;
	logic                       code_valid;
	logic [`SD_LBA_W-1:0]       sd_lba;
	logic                       sd_rd, sd_wr;
	logic                       sd_ack = 1'b0;
	logic                       img_mounted, img_readonly;
	logic [63:0]                img_size;
	logic                       osd_status, bk_load_req, bk_save_req, autosave_en, nvram_we;
	logic                       bk_busy, bk_loading, bk_pending;

	int err_count     = 0;
	int test_count    = 0;
	int failed_tests  = 0;
	int cycle_count   = 0;
	int valid_count   = 0; // code_valid pulses
	int overlap_count = 0; // Strobes with wait high, or wait low while an ack is late

	logic [7:0] dl_data [0:511]; // Bytes of the next download
	logic [7:0] rom_mem [0:1023];
	int         wr_addr_log[$];
	logic [7:0] wr_data_log[$];
	int         sec_lba_log[$];
	bit         sec_rd_log[$];

	console_top dut_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_count++;
		if (rst_n && ioctl_wr && ioctl_wait) overlap_count++;
		if (rst_n && rom_wr != rom_wr_ack && !ioctl_wait) overlap_count++; // Ack outstanding
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout, the run was stopped after %0d cycles", cycle_count);
			$display("Verification failed");
			$finish;
		end
	end

	// ==============================
	// ROM memory and sector host
	// ==============================
	always begin
		@(negedge clk_sys);
		if (rst_n && rom_wr != rom_wr_ack) begin
			repeat ($urandom_range(0, 3)) @(negedge clk_sys);
			rom_mem[rom_waddr[9:0]] = rom_din;
			wr_addr_log.push_back(int'(rom_waddr));
			wr_data_log.push_back(rom_din);
			rom_wr_ack = rom_wr; // Toggle answered
		end
	end

	always begin
		@(negedge clk_sys);
		if (rst_n && (sd_rd || sd_wr) && !sd_ack) begin
			sec_lba_log.push_back(int'(sd_lba));
			sec_rd_log.push_back(sd_rd);
			repeat ($urandom_range(0, 3)) @(negedge clk_sys);
			sd_ack = 1'b1;
			repeat (1 + $urandom_range(0, 3)) @(negedge clk_sys);
			sd_ack = 1'b0; // Falling ack asks for the next sector
		end
	end

	always @(negedge clk_sys) begin
		if (code_valid) valid_count++;
	end

	task automatic log_error(input string msg);
		err_count++;
		$display("ERR %0d ns: %s", $time, msg);
	endtask

	task automatic finish_test(input string name, input int errs_before);
		test_count++;
		if (err_count == errs_before) begin
			$display("test %-18s ok", name);
		end else begin
			failed_tests++;
			$display("test %-18s FAILED, %0d errors", name, err_count - errs_before);
		end
	endtask

	task automatic host_write(input int addr, input logic [7:0] data, input bit cart);
		while (ioctl_wait) @(negedge clk_sys);
		ioctl_addr = `IOCTL_ADDR_W'(addr);
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		if (cart && !ioctl_wait) log_error($sformatf("wait low after write of address %0d", addr));
		while (ioctl_wait) @(negedge clk_sys);
	endtask

	task automatic download_image(input logic [7:0] index, input int nbytes);
		int i;
		ioctl_index    = index;
		ioctl_download = 1'b1;
		@(negedge clk_sys); // Rising edge of download seen first
		for (i = 0; i < nbytes; i++) host_write(i, dl_data[i], index[7:2] == 6'd0);
		ioctl_download = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic wait_backup_done(input bit expect_loading);
		int n;
		n = 0;
		while (!bk_busy && n < 10) begin
			@(negedge clk_sys);
			n++;
		end
		if (!bk_busy) begin
			err_count++;
			$display("The backup transfer did not start, bk_busy stayed low");
		end else begin
			if (bk_loading != expect_loading)
				log_error($sformatf("bk_loading %0b at start, expected %0b",
					bk_loading, expect_loading));
			while (bk_busy) @(negedge clk_sys);
			if (bk_loading) log_error("bk_loading still high after bk_busy fell");
		end
	endtask

	task automatic check_sectors(input bit expect_rd);
		int i;
		if (sec_lba_log.size() != SECTORS) begin
			log_error($sformatf("%0d sector requests, expected %0d", sec_lba_log.size(), SECTORS));
		end else begin
			for (i = 0; i < SECTORS; i++) begin
				if (sec_lba_log[i] != i || sec_rd_log[i] != expect_rd)
					log_error($sformatf("request %0d lba %0d rd %0b, expected lba %0d rd %0b",
						i, sec_lba_log[i], sec_rd_log[i], i, expect_rd));
			end
		end
	endtask

	task automatic check_spacing(input string name, input int now, inout int last,
		input int period, inout int count);
		if (last >= 0 && now - last != period)
			log_error($sformatf("%s spacing %0d, expected %0d", name, now - last, period));
		last = now;
		count++;
	endtask

	// ==============================
	// Directed tests
	// ==============================
	task automatic clock_enable_pattern();
		int errs, i, last_vdp, last_pix, last_cpu, n_vdp, n_pix, n_cpu;
		errs     = err_count;
		last_vdp = -1;
		last_pix = -1;
		last_cpu = -1;
		n_vdp    = 0;
		n_pix    = 0;
		n_cpu    = 0;
		for (i = 0; i < 90; i++) begin
			@(negedge clk_sys);
			if ((ce_pix || ce_cpu) && !ce_vdp) log_error("ce_pix or ce_cpu without ce_vdp");
			if (ce_vdp) check_spacing("ce_vdp", i, last_vdp, 5, n_vdp);
			if (ce_pix) check_spacing("ce_pix", i, last_pix, 10, n_pix);
			if (ce_cpu) check_spacing("ce_cpu", i, last_cpu, 15, n_cpu);
		end
		if (n_vdp != 18 || n_pix != 9 || n_cpu != 6)
			log_error($sformatf("pulse counts %0d/%0d/%0d, expected 18/9/6", n_vdp, n_pix, n_cpu));
		finish_test("clock enables", errs);
	endtask

	task automatic cart_byte_order();
		int errs, i;
		errs = err_count;
		wr_addr_log.delete();
		wr_data_log.delete();
		overlap_count = 0;
		for (i = 0; i < 40; i++) dl_data[i] = 8'($urandom);
		download_image(8'd0, 40);
		if (wr_addr_log.size() != 40) log_error($sformatf("%0d ROM writes", wr_addr_log.size()));
		for (i = 0; i < 40 && i < wr_addr_log.size(); i++) begin
			if (wr_addr_log[i] != i || wr_data_log[i] != dl_data[i] || rom_mem[i] != dl_data[i])
				log_error($sformatf("write %0d at %0d data %h, expected %h",
					i, wr_addr_log[i], wr_data_log[i], dl_data[i]));
		end
		if (overlap_count != 0)
			log_error("host strobed with ioctl_wait high, or wait fell before the ack");
		finish_test("cart download", errs);
	endtask

	task automatic mask_and_sys_type();
		int errs, i;
		logic [`ROM_ADDR_W-1:0] exp_mask;
		errs     = err_count;
		exp_mask = '0;
		for (i = 0; i < 300; i++) begin
			dl_data[i] = 8'(i * 7);
			if (i != 0) exp_mask = exp_mask | `ROM_ADDR_W'(i);
		end
		download_image(8'(`IDX_HANDHELD), 300);
		if (cart_mask != exp_mask) log_error($sformatf("cart_mask %h, expected %h", cart_mask, exp_mask));
		if (!sys_handheld || sys_arcade) log_error("system type is not handheld");
		for (i = 0; i < 4; i++) begin
			core_rom_addr = `ROM_ADDR_W'($urandom);
			@(negedge clk_sys);
			if (rom_raddr != (core_rom_addr & exp_mask))
				log_error($sformatf("rom_raddr %h for core address %h", rom_raddr, core_rom_addr));
		end
		finish_test("mask and type", errs);
	endtask

	task automatic cheat_code_assembly();
		int errs, i;
		logic [31:0] exp_f [0:3];
		logic [31:0] got_f [0:3];
		errs        = err_count;
		valid_count = 0;
		for (i = 0; i < `CODE_BYTES; i++) dl_data[i] = 8'($urandom);
		download_image(8'(`IDX_CHEAT), `CODE_BYTES);
		repeat (2) @(negedge clk_sys);
		for (i = 0; i < 4; i++)
			exp_f[i] = {dl_data[4*i+3], dl_data[4*i+2], dl_data[4*i+1], dl_data[4*i]};
		got_f[0] = code.fields.flags;
		got_f[1] = code.fields.address;
		got_f[2] = code.fields.compare;
		got_f[3] = code.fields.replace;
		for (i = 0; i < 4; i++) begin
			if (got_f[i] != exp_f[i])
				log_error($sformatf("code field %0d is %h, expected %h", i, got_f[i], exp_f[i]));
		end
		if (valid_count != 1) log_error($sformatf("code_valid pulsed %0d times", valid_count));
		finish_test("cheat code", errs);
	endtask

	task automatic backup_load_after_download();
		int errs, i;
		errs = err_count;
		sec_lba_log.delete();
		sec_rd_log.delete();
		img_mounted  = 1'b1; // Writable save image
		img_readonly = 1'b0;
		img_size     = 64'd32768;
		for (i = 0; i < 16; i++) dl_data[i] = 8'($urandom);
		download_image(8'(`IDX_HANDHELD), 16);
		wait_backup_done(1'b1);
		check_sectors(1'b1);
		finish_test("backup load", errs);
	endtask

	task automatic autosave_on_menu_open();
		int errs;
		errs = err_count;
		sec_lba_log.delete();
		sec_rd_log.delete();
		autosave_en = 1'b1;
		nvram_we    = 1'b1;
		@(negedge clk_sys);
		nvram_we = 1'b0;
		@(negedge clk_sys);
		if (!bk_pending) log_error("bk_pending not set after nvram_we");
		osd_status = 1'b1; // Menu opens
		wait_backup_done(1'b0);
		check_sectors(1'b0);
		if (bk_pending) log_error("bk_pending still set after the save");
		osd_status = 1'b0;
		finish_test("autosave", errs);
	endtask

	initial begin
		rst_n          = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		core_rom_addr  = '0;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		img_size       = '0;
		osd_status     = 1'b0;
		bk_load_req    = 1'b0;
		bk_save_req    = 1'b0;
		autosave_en    = 1'b0;
		nvram_we       = 1'b0;
		void'($urandom(89));
		repeat (8) @(negedge clk_sys);
		rst_n = 1'b1;
		@(negedge clk_sys);

		clock_enable_pattern();
		cart_byte_order();
		mask_and_sys_type();
		cheat_code_assembly();
		backup_load_after_download();
		autosave_on_menu_open();

		if (dut_i.checker_i.fail_count != 0) begin
			$display("The checker saw %0d assertion failures", dut_i.checker_i.fail_count);
			err_count += dut_i.checker_i.fail_count;
		end
		$display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, err_count);
		if (err_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* filelist.f */
+incdir+.
console_pkg.sv
download_if.sv
clock_enable_gen.sv
cart_loader.sv
cheat_code_loader.sv
backup_sequencer.sv
console_top.sv
console_checker.sv
console_tb.sv

/* Makefile */
# Verilator build and run of the console testbench

VERILATOR ?= verilator
TOP       ?= console_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Verification passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
